//--- logic/conv_pkg.sv
package conv_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Operand, modulo and result width
  localparam int DATA_W = 16;
  // Size and length counter width
  localparam int CNT_W = 8;

  //////////////////////////////////////////////////
  // Plain vectors
  //////////////////////////////////////////////////

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0] count_t;

  //////////////////////////////////////////////////
  // Configuration
  //////////////////////////////////////////////////

  // Register addresses, value 3 unmapped
  typedef enum logic [1:0] {
    CFG_MODULO = 2'd0,
    CFG_SIZE   = 2'd1,
    CFG_LENGTH = 2'd2
  } cfg_addr_e;

  // Live configuration, 32 bits
  typedef struct packed {
    data_t  modulo;
    count_t size;
    count_t length;
  } cfg_t;

  // One write access
  typedef struct packed {
    logic      valid;
    cfg_addr_e addr;
    data_t     data;
  } cfg_wr_t;

  //////////////////////////////////////////////////
  // Streams
  //////////////////////////////////////////////////

  // Operand pair on the input stream
  typedef struct packed {
    data_t a;
    data_t b;
  } pair_t;

  // Result beat with group and vector markers
  typedef struct packed {
    data_t data;
    logic  group_last;
    logic  vector_last;
  } out_beat_t;

  // Sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE    = 2'd0,
    SEQ_FETCH   = 2'd1,
    SEQ_COMPUTE = 2'd2,
    SEQ_EMIT    = 2'd3
  } seq_state_e;

endpackage

//--- logic/conv_config_regs.sv
`timescale 1ns/1ps

module conv_config_regs (
  input  logic                CLK,
  input  logic                RST,
  input  conv_pkg::cfg_wr_t   cfg_wr,
  input  conv_pkg::cfg_addr_e cfg_rd_addr,
  input  logic                busy,
  output conv_pkg::data_t     cfg_rd_data,
  output conv_pkg::cfg_t      cfg
);

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  // Accepted only while no run is active
  logic wr_en;

  assign wr_en = cfg_wr.valid && !busy;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // Smallest legal run after reset
      cfg.modulo <= conv_pkg::data_t'(1);
      cfg.size   <= conv_pkg::count_t'(1);
      cfg.length <= conv_pkg::count_t'(1);
    end else if (wr_en) begin
      case (cfg_wr.addr)
        conv_pkg::CFG_MODULO: begin
          cfg.modulo <= cfg_wr.data;
        end
        conv_pkg::CFG_SIZE: begin
          // Upper bits dropped
          cfg.size <= cfg_wr.data[conv_pkg::CNT_W-1:0];
        end
        conv_pkg::CFG_LENGTH: begin
          cfg.length <= cfg_wr.data[conv_pkg::CNT_W-1:0];
        end
        default: begin
          // Unmapped address, nothing stored
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////

  always_comb begin
    case (cfg_rd_addr)
      conv_pkg::CFG_MODULO: cfg_rd_data = cfg.modulo;
      // Counters zero extended
      conv_pkg::CFG_SIZE:   cfg_rd_data = conv_pkg::data_t'(cfg.size);
      conv_pkg::CFG_LENGTH: cfg_rd_data = conv_pkg::data_t'(cfg.length);
      default:              cfg_rd_data = '0;
    endcase
  end

endmodule

//--- logic/conv_pair_fifo.sv
`timescale 1ns/1ps

module conv_pair_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic            CLK,
  input  logic            RST,
  input  logic            pair_valid,
  input  conv_pkg::pair_t in_pair,
  input  logic            pop,
  output conv_pkg::pair_t head,
  output logic            empty,
  output logic            pair_credit
);

  // Pointer and occupancy widths
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  conv_pkg::pair_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] occ;

  // Sender credit rule keeps occupancy in range
  always_ff @(posedge CLK) begin
    if (pair_valid) begin
      mem[wr_ptr] <= in_pair;
    end
  end

  //////////////////////////////////////////////////
  // Pointers, occupancy, credit return
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      occ         <= '0;
      pair_credit <= 1'b0;
    end else begin
      // Wrap at depth, depth need not be a power of two
      if (pair_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({pair_valid, pop})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
      // One credit back, one cycle after the pop
      pair_credit <= pop;
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (occ == '0);

endmodule

//--- logic/conv_modular_mac.sv
`timescale 1ns/1ps

module conv_modular_mac (
  input  logic            CLK,
  input  logic            RST,
  input  conv_pkg::cfg_t  cfg,
  input  logic            mac_start,
  input  conv_pkg::pair_t mac_pair,
  input  logic            mac_clear,
  output logic            mac_done,
  output conv_pkg::data_t mac_result
);

  localparam int W = conv_pkg::DATA_W;
  localparam int STEP_W = $clog2(W);

  //////////////////////////////////////////////////
  // Restoring remainder step
  //////////////////////////////////////////////////

  // Shift one dividend bit into r, subtract m when it fits
  function automatic conv_pkg::data_t mod_step(
    input conv_pkg::data_t r,
    input logic            bit_in,
    input conv_pkg::data_t m
  );
    logic [W:0] t;
    t = {r, bit_in};
    if (t >= {1'b0, m}) begin
      t = t - {1'b0, m};
    end
    return t[W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // Datapath registers
  //////////////////////////////////////////////////

  logic [2*W-1:0]  prod;
  conv_pkg::data_t rem;
  conv_pkg::data_t rem_next;
  conv_pkg::data_t sum_q;
  conv_pkg::data_t acc;
  logic            clear_q;
  logic [W:0]      sum_raw;
  conv_pkg::data_t sum_mod;

  // Pipeline control
  logic              red_active;
  logic [STEP_W-1:0] red_cnt;
  logic              acc_pending;
  logic              out_pending;

  // Two product bits per step, MSB first, so 2W bits drain in W steps
  assign rem_next = mod_step(mod_step(rem, prod[2*W-1], cfg.modulo),
                             prod[2*W-2], cfg.modulo);

  // Both terms below modulo, one subtract is enough
  always_comb begin
    sum_raw = {1'b0, (clear_q ? '0 : acc)} + {1'b0, rem};
    sum_mod = sum_raw[W-1:0];
    if (sum_raw >= {1'b0, cfg.modulo}) begin
      sum_mod = W'(sum_raw - {1'b0, cfg.modulo});
    end
  end

  always_ff @(posedge CLK) begin
    if (mac_start) begin
      prod    <= mac_pair.a * mac_pair.b;
      rem     <= '0;
      clear_q <= mac_clear;
    end else if (red_active) begin
      prod <= prod << 2;
      rem  <= rem_next;
    end
    if (acc_pending) begin
      sum_q <= sum_mod;
    end
  end

  //////////////////////////////////////////////////
  // Sequencing, done DATA_W+3 cycles after start
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      red_active  <= 1'b0;
      red_cnt     <= '0;
      acc_pending <= 1'b0;
      out_pending <= 1'b0;
      mac_done    <= 1'b0;
      acc         <= '0;
    end else begin
      mac_done    <= 1'b0;
      acc_pending <= 1'b0;
      out_pending <= acc_pending;
      if (mac_start) begin
        // Product lands this edge
        red_active <= 1'b1;
        red_cnt    <= '0;
      end else if (red_active) begin
        red_cnt <= red_cnt + 1'b1;
        if (red_cnt == STEP_W'(W - 1)) begin
          red_active  <= 1'b0;
          acc_pending <= 1'b1;
        end
      end
      // Result stage
      if (out_pending) begin
        acc      <= sum_q;
        mac_done <= 1'b1;
      end
    end
  end

  // Held until the next run finishes
  assign mac_result = acc;

endmodule

//--- logic/conv_vector_sequencer.sv
`timescale 1ns/1ps

module conv_vector_sequencer #(
  parameter int OUT_CREDITS = 2
) (
  input  logic                CLK,
  input  logic                RST,
  input  logic                START,
  input  conv_pkg::cfg_t      cfg,
  output logic                busy,
  input  logic                empty,
  input  conv_pkg::pair_t     head,
  output logic                pop,
  output logic                mac_start,
  output conv_pkg::pair_t     mac_pair,
  output logic                mac_clear,
  input  logic                mac_done,
  input  conv_pkg::data_t     mac_result,
  input  logic                out_credit,
  output logic                out_valid,
  output conv_pkg::out_beat_t out_beat
);

  localparam int CR_W = $clog2(OUT_CREDITS + 1);

  //////////////////////////////////////////////////
  // State and counters
  //////////////////////////////////////////////////

  conv_pkg::seq_state_e state;
  conv_pkg::count_t     grp_idx;
  conv_pkg::count_t     elem_idx;
  logic [CR_W-1:0]      credits;

  // Position flags for the current element
  logic group_last;
  logic vector_last;
  // Beat leaves this edge
  logic send;

  assign group_last  = (elem_idx == cfg.length - conv_pkg::count_t'(1));
  assign vector_last = group_last && (grp_idx == cfg.size - conv_pkg::count_t'(1));

  // Head is consumed the cycle it is taken
  assign pop  = (state == conv_pkg::SEQ_FETCH) && !empty;
  assign send = (state == conv_pkg::SEQ_EMIT) && (credits != '0);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= conv_pkg::SEQ_IDLE;
      busy      <= 1'b0;
      grp_idx   <= '0;
      elem_idx  <= '0;
      mac_start <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      // Single cycle strobes
      mac_start <= 1'b0;
      out_valid <= 1'b0;
      case (state)
        conv_pkg::SEQ_IDLE: begin
          // Drops one cycle after the last beat
          busy <= 1'b0;
          if (START) begin
            busy     <= 1'b1;
            grp_idx  <= '0;
            elem_idx <= '0;
            state    <= conv_pkg::SEQ_FETCH;
          end
        end
        conv_pkg::SEQ_FETCH: begin
          if (pop) begin
            mac_start <= 1'b1;
            state     <= conv_pkg::SEQ_COMPUTE;
          end
        end
        conv_pkg::SEQ_COMPUTE: begin
          if (mac_done) begin
            state <= conv_pkg::SEQ_EMIT;
          end
        end
        conv_pkg::SEQ_EMIT: begin
          // Stall here without credit, core keeps the result
          if (send) begin
            out_valid <= 1'b1;
            if (group_last) begin
              elem_idx <= '0;
              grp_idx  <= grp_idx + 1'b1;
            end else begin
              elem_idx <= elem_idx + 1'b1;
            end
            state <= vector_last ? conv_pkg::SEQ_IDLE : conv_pkg::SEQ_FETCH;
          end
        end
        default: begin
          state <= conv_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Core operands and result beat
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (pop) begin
      mac_pair <= head;
      // Accumulator restarts with each group
      mac_clear <= (elem_idx == '0);
    end
    if (send) begin
      out_beat.data        <= mac_result;
      out_beat.group_last  <= group_last;
      out_beat.vector_last <= vector_last;
    end
  end

  //////////////////////////////////////////////////
  // Output credits
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits <= CR_W'(OUT_CREDITS);
    end else begin
      // Return and spend together cancel
      case ({out_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

//--- logic/conv_top.sv
`timescale 1ns/1ps

module conv_top #(
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                CLK,
  input  logic                RST,
  input  logic                START,
  output logic                busy,
  input  conv_pkg::cfg_wr_t   cfg_wr,
  input  conv_pkg::cfg_addr_e cfg_rd_addr,
  output conv_pkg::data_t     cfg_rd_data,
  input  logic                pair_valid,
  input  conv_pkg::pair_t     in_pair,
  output logic                pair_credit,
  output logic                out_valid,
  output conv_pkg::out_beat_t out_beat,
  input  logic                out_credit
);

  //////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////

  // Live configuration
  conv_pkg::cfg_t  cfg;
  // FIFO to sequencer
  logic            empty;
  conv_pkg::pair_t head;
  logic            pop;
  // Sequencer to core
  logic            mac_start;
  conv_pkg::pair_t mac_pair;
  logic            mac_clear;
  logic            mac_done;
  conv_pkg::data_t mac_result;

  conv_config_regs conv_config_regs_inst (
    .CLK         (CLK),
    .RST         (RST),
    .cfg_wr      (cfg_wr),
    .cfg_rd_addr (cfg_rd_addr),
    .busy        (busy),
    .cfg_rd_data (cfg_rd_data),
    .cfg         (cfg)
  );

  conv_pair_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) conv_pair_fifo_inst (
    .CLK         (CLK),
    .RST         (RST),
    .pair_valid  (pair_valid),
    .in_pair     (in_pair),
    .pop         (pop),
    .head        (head),
    .empty       (empty),
    .pair_credit (pair_credit)
  );

  conv_vector_sequencer #(
    .OUT_CREDITS (OUT_CREDITS)
  ) conv_vector_sequencer_inst (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .cfg        (cfg),
    .busy       (busy),
    .empty      (empty),
    .head       (head),
    .pop        (pop),
    .mac_start  (mac_start),
    .mac_pair   (mac_pair),
    .mac_clear  (mac_clear),
    .mac_done   (mac_done),
    .mac_result (mac_result),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_beat   (out_beat)
  );

  conv_modular_mac conv_modular_mac_inst (
    .CLK        (CLK),
    .RST        (RST),
    .cfg        (cfg),
    .mac_start  (mac_start),
    .mac_pair   (mac_pair),
    .mac_clear  (mac_clear),
    .mac_done   (mac_done),
    .mac_result (mac_result)
  );

endmodule

//--- dv/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

  localparam int FIFO_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;
  localparam int NUM_RUNS    = 7;
  // Cycle limit of each wait loop
  localparam int WAIT_LIMIT  = 20000;

  //////////////////////////////////////////////////
  // Run table
  //////////////////////////////////////////////////

  // gap is the number of idle cycles between credit returns
  typedef struct packed {
    logic [15:0] modulo;
    logic [7:0]  size;
    logic [7:0]  length;
    logic [7:0]  gap;
    logic        wr_busy;
  } run_t;

  // modulo, size, length, gap, write while busy
  run_t runs [NUM_RUNS] = '{
    '{16'd97,    8'd1, 8'd5, 8'd0,  1'b0},
    '{16'd65521, 8'd1, 8'd8, 8'd2,  1'b0},
    '{16'd13,    8'd3, 8'd4, 8'd1,  1'b1},
    '{16'd1,     8'd2, 8'd3, 8'd0,  1'b0},
    '{16'd251,   8'd4, 8'd2, 8'd60, 1'b1},
    '{16'd40000, 8'd2, 8'd6, 8'd45, 1'b0},
    '{16'd7,     8'd5, 8'd1, 8'd3,  1'b1}
  };

  //////////////////////////////////////////////////
  // DUT
  //////////////////////////////////////////////////

  logic                CLK = 1'b0;
  logic                RST;
  logic                START;
  logic                busy;
  conv_pkg::cfg_wr_t   cfg_wr;
  conv_pkg::cfg_addr_e cfg_rd_addr;
  conv_pkg::data_t     cfg_rd_data;
  logic                pair_valid = 1'b0;
  conv_pkg::pair_t     in_pair = '0;
  logic                pair_credit;
  logic                out_valid;
  conv_pkg::out_beat_t out_beat;
  logic                out_credit = 1'b0;

  conv_top #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) conv_top_inst (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .busy        (busy),
    .cfg_wr      (cfg_wr),
    .cfg_rd_addr (cfg_rd_addr),
    .cfg_rd_data (cfg_rd_data),
    .pair_valid  (pair_valid),
    .in_pair     (in_pair),
    .pair_credit (pair_credit),
    .out_valid   (out_valid),
    .out_beat    (out_beat),
    .out_credit  (out_credit)
  );

  // 20 ns period
  always #10 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Scoreboard state
  //////////////////////////////////////////////////

  conv_pkg::pair_t     send_q [$];
  conv_pkg::out_beat_t exp_q [$];
  int in_credits;
  int credit_pulses;
  int pending_credits;
  int beats_rx;
  int last_beat_cycle;
  int gap_cnt;
  int gap_cycles;
  int cycle;

  always @(posedge CLK) begin
    if (RST) begin
      cycle <= 0;
    end else begin
      cycle <= cycle + 1;
    end
  end

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Running group sum of a*b, reduced mod modulo
  function automatic conv_pkg::data_t expected_sum(
    input conv_pkg::data_t acc,
    input conv_pkg::pair_t p,
    input conv_pkg::data_t modulo,
    input logic            clear
  );
    logic [63:0] total;
    total = 64'(p.a) * 64'(p.b);
    if (!clear) begin
      total = total + 64'(acc);
    end
    return conv_pkg::data_t'(total % 64'(modulo));
  endfunction

  //////////////////////////////////////////////////
  // Input sender, credit based
  //////////////////////////////////////////////////

  always @(posedge CLK) begin : sender
    int credits_now;
    credits_now = in_credits;
    if (RST) begin
      pair_valid    <= 1'b0;
      in_credits    <= FIFO_DEPTH;
      credit_pulses <= 0;
    end else begin
      // One slot back per pulse
      if (pair_credit) begin
        credits_now = credits_now + 1;
        credit_pulses <= credit_pulses + 1;
      end
      check_value("in_credits_within_depth", 32'(credits_now <= FIFO_DEPTH), 32'd1);
      if (credits_now > 0 && send_q.size() > 0) begin
        pair_valid  <= 1'b1;
        in_pair     <= send_q.pop_front();
        credits_now = credits_now - 1;
      end else begin
        pair_valid <= 1'b0;
      end
      in_credits <= credits_now;
    end
  end

  //////////////////////////////////////////////////
  // Output receiver and checker
  //////////////////////////////////////////////////

  always @(posedge CLK) begin : receiver
    int pend;
    int gap_now;
    conv_pkg::out_beat_t exp_beat;
    pend    = pending_credits;
    gap_now = gap_cnt;
    if (RST) begin
      out_credit      <= 1'b0;
      pending_credits <= 0;
      beats_rx        <= 0;
      last_beat_cycle <= 0;
      gap_cnt         <= 0;
    end else begin
      out_credit <= 1'b0;
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          stop_on_failure("result beat arrived while none was expected");
        end else begin
          exp_beat = exp_q.pop_front();
          check_value("out_beat.data", 32'(out_beat.data), 32'(exp_beat.data));
          check_value("out_beat.group_last", 32'(out_beat.group_last),
                      32'(exp_beat.group_last));
          check_value("out_beat.vector_last", 32'(out_beat.vector_last),
                      32'(exp_beat.vector_last));
          // Still busy on the last beat itself
          check_value("busy", 32'(busy), 32'd1);
          // Beats held here, each owes one credit
          pend = pend + 1;
          check_value("beats_outstanding_within_credits", 32'(pend <= OUT_CREDITS), 32'd1);
          beats_rx <= beats_rx + 1;
          if (out_beat.vector_last) begin
            last_beat_cycle <= cycle;
          end
        end
      end
      // Slow credit return stalls the sequencer
      if (pend > 0) begin
        if (gap_now >= gap_cycles) begin
          out_credit <= 1'b1;
          pend    = pend - 1;
          gap_now = 0;
        end else begin
          gap_now = gap_now + 1;
        end
      end
      pending_credits <= pend;
      gap_cnt         <= gap_now;
    end
  end

  //////////////////////////////////////////////////
  // Register access and waits
  //////////////////////////////////////////////////

  task automatic write_cfg(input conv_pkg::cfg_addr_e addr, input conv_pkg::data_t data);
    cfg_wr.valid <= 1'b1;
    cfg_wr.addr  <= addr;
    cfg_wr.data  <= data;
    @(posedge CLK);
    cfg_wr.valid <= 1'b0;
  endtask

  // Combinational readback, sampled one edge later
  task automatic expect_readback(input conv_pkg::cfg_addr_e addr,
                                 input conv_pkg::data_t exp);
    cfg_rd_addr <= addr;
    @(posedge CLK);
    check_value("cfg_rd_data", 32'(cfg_rd_data), 32'(exp));
  endtask

  task automatic wait_for_busy(input logic level, input string what, output int at_cycle);
    int n;
    n = 0;
    @(posedge CLK);
    while (busy !== level && n < WAIT_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    if (busy !== level) begin
      stop_on_failure({"timeout: ", what});
    end
    at_cycle = cycle;
  endtask

  task automatic wait_for_credit_return();
    int n;
    n = 0;
    while (pending_credits != 0 && n < WAIT_LIMIT) begin
      @(posedge CLK);
      n++;
    end
    if (pending_credits != 0) begin
      stop_on_failure("timeout: receiver never returned all output credits");
    end
  endtask

  //////////////////////////////////////////////////
  // One table row
  //////////////////////////////////////////////////

  task automatic execute_run(input run_t r);
    int total;
    int base_pulses;
    int base_beats;
    int start_cycle;
    int rise_cycle;
    int fall_cycle;
    conv_pkg::data_t     acc;
    conv_pkg::pair_t     p;
    conv_pkg::out_beat_t b;

    write_cfg(conv_pkg::CFG_MODULO, r.modulo);
    write_cfg(conv_pkg::CFG_SIZE, 16'(r.size));
    write_cfg(conv_pkg::CFG_LENGTH, 16'(r.length));
    expect_readback(conv_pkg::CFG_MODULO, r.modulo);
    expect_readback(conv_pkg::CFG_SIZE, 16'(r.size));
    expect_readback(conv_pkg::CFG_LENGTH, 16'(r.length));
    gap_cycles = int'(r.gap);

    // Operands and expected beats
    total = int'(r.size) * int'(r.length);
    acc   = '0;
    for (int g = 0; g < int'(r.size); g++) begin
      for (int e = 0; e < int'(r.length); e++) begin
        p.a           = conv_pkg::data_t'($urandom);
        p.b           = conv_pkg::data_t'($urandom);
        acc           = expected_sum(acc, p, r.modulo, e == 0);
        b.data        = acc;
        b.group_last  = (e == int'(r.length) - 1);
        b.vector_last = b.group_last && (g == int'(r.size) - 1);
        exp_q.push_back(b);
        send_q.push_back(p);
      end
    end
    base_pulses = credit_pulses;
    base_beats  = beats_rx;

    START <= 1'b1;
    @(posedge CLK);
    // Edge that samples START
    start_cycle = cycle;
    START <= 1'b0;
    wait_for_busy(1'b1, "busy did not rise after START", rise_cycle);
    check_value("busy_rise_cycle", rise_cycle, start_cycle + 1);
    // Locked registers, these must be dropped
    if (r.wr_busy) begin
      write_cfg(conv_pkg::CFG_MODULO, r.modulo + 16'd2);
      write_cfg(conv_pkg::CFG_LENGTH, 16'(r.length) + 16'd1);
    end
    wait_for_busy(1'b0, "busy did not fall at the end of the run", fall_cycle);
    check_value("busy_fall_cycle", fall_cycle, last_beat_cycle + 1);

    wait_for_credit_return();
    check_value("beats_per_run", beats_rx - base_beats, total);
    check_value("exp_q_left", exp_q.size(), 0);
    check_value("pair_credit_pulses", credit_pulses - base_pulses, total);
    check_value("in_credits", in_credits, FIFO_DEPTH);
    expect_readback(conv_pkg::CFG_MODULO, r.modulo);
    expect_readback(conv_pkg::CFG_SIZE, 16'(r.size));
    expect_readback(conv_pkg::CFG_LENGTH, 16'(r.length));
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    void'($urandom(32'h38c5));
    gap_cycles  = 0;
    RST         <= 1'b1;
    START       <= 1'b0;
    cfg_wr      <= '0;
    cfg_rd_addr <= conv_pkg::CFG_MODULO;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);

    // Idle outputs and reset values
    check_value("busy", 32'(busy), 32'd0);
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("pair_credit", 32'(pair_credit), 32'd0);
    expect_readback(conv_pkg::CFG_MODULO, 16'd1);
    expect_readback(conv_pkg::CFG_SIZE, 16'd1);
    expect_readback(conv_pkg::CFG_LENGTH, 16'd1);

    for (int i = 0; i < NUM_RUNS; i++) begin
      execute_run(runs[i]);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- src.f
logic/conv_pkg.sv
logic/conv_config_regs.sv
logic/conv_pair_fifo.sv
logic/conv_modular_mac.sv
logic/conv_vector_sequencer.sv
logic/conv_top.sv
dv/conv_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module conv_tb -f src.f -o conv_sim
	./obj_dir/conv_sim | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
